// File: hdl/vrt_pkg.sv
// ******************************
// Shared widths, queue depth, APB register map and runtime FSM states
// QueueDepth must be a power of two so the queue pointers wrap freely
// ******************************

package vrt_pkg;

  // Instruction word is {tag, length}, tag only travels along for tracing
  localparam int unsigned InstrLenWidth = 4;
  localparam int unsigned InstrIdWidth  = 4;
  localparam int unsigned InstrWidth    = InstrIdWidth + InstrLenWidth;

  // Queue depth doubles as the number of credits the dispatcher starts with
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned QueuePtrWidth = $clog2(QueueDepth);
  // Wide enough to hold the value QueueDepth itself
  localparam int unsigned CreditWidth   = 3;

  localparam int unsigned RuntimeWidth  = 64;

  localparam int unsigned ApbAddrWidth  = 12;
  localparam int unsigned ApbDataWidth  = 32;

  // Register offsets inside the APB window
  localparam logic [ApbAddrWidth-1:0] RegCtrl      = 12'h000;
  localparam logic [ApbAddrWidth-1:0] RegStatus    = 12'h004;
  localparam logic [ApbAddrWidth-1:0] RegRuntimeLo = 12'h008;
  localparam logic [ApbAddrWidth-1:0] RegRuntimeHi = 12'h00C;

  // Bit positions inside RegStatus
  localparam int unsigned StatusCountingBit = 0;
  localparam int unsigned StatusPendingBit  = 1;
  localparam int unsigned StatusIdleBit     = 2;

  // RtOff is stopped and clean, RtRun is counting, RtDrain has stopped
  // counting but may still owe a buffer update
  typedef enum logic [1:0] {
    RtOff   = 2'd0,
    RtRun   = 2'd1,
    RtDrain = 2'd2
  } rt_state_e;

endpackage : vrt_pkg

// File: hdl/vrt_instr_queue.sv
// ******************************
// Credited instruction FIFO, a push while full is a protocol error
// and is not blocked here
// ******************************

`timescale 1ns/1ps

module vrt_instr_queue (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             push_i,
  input  logic [vrt_pkg::InstrWidth-1:0]   data_i,
  input  logic                             pop_i,
  output logic                             valid_o,
  output logic [vrt_pkg::InstrWidth-1:0]   data_o,
  output logic                             empty_o,
  output logic                             credit_o
);

  logic [vrt_pkg::InstrWidth-1:0]    mem_q [vrt_pkg::QueueDepth];
  logic [vrt_pkg::QueuePtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [vrt_pkg::CreditWidth-1:0]   count_q;
  logic                              credit_q;

  // Storage carries payload only, no reset needed
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      // Pointers wrap on their own since the depth is a power of two
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_i)  rd_ptr_q <= rd_ptr_q + 1'b1;
      // Occupancy only moves when exactly one side is active
      if (push_i && !pop_i) begin
        count_q <= count_q + 1'b1;
      end else if (pop_i && !push_i) begin
        count_q <= count_q - 1'b1;
      end
      // Every freed slot is handed back to the dispatcher one cycle later
      credit_q <= pop_i;
    end
  end

  assign empty_o  = (count_q == '0);
  assign valid_o  = !empty_o;
  assign data_o   = mem_q[rd_ptr_q];
  assign credit_o = credit_q;

endmodule : vrt_instr_queue

// File: hdl/vrt_vector_unit.sv
// ******************************
// Busy model of a vector unit, one instruction in flight at a time
// A length field of zero executes for one cycle
// ******************************

`timescale 1ns/1ps

module vrt_vector_unit (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           valid_i,
  input  logic [vrt_pkg::InstrWidth-1:0] instr_i,
  output logic                           pop_o,
  output logic                           idle_o
);

  // Cycles left of the instruction being executed
  logic [vrt_pkg::InstrLenWidth-1:0] remain_q;
  logic [vrt_pkg::InstrLenWidth-1:0] len_raw;
  logic [vrt_pkg::InstrLenWidth-1:0] len_eff;
  logic                              busy;

  // Length sits in the low bits, the tag above it is not needed here
  assign len_raw = instr_i[vrt_pkg::InstrLenWidth-1:0];

  // Zero length still occupies the unit for a single cycle
  assign len_eff = (len_raw == '0) ? 1'b1 : len_raw;

  assign busy   = (remain_q != '0);
  assign idle_o = !busy;

  // Take the next entry in the very cycle the unit goes quiet
  assign pop_o = idle_o && valid_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      remain_q <= '0;
    end else if (pop_o) begin
      // Busy from this edge for exactly len_eff cycles
      remain_q <= len_eff;
    end else if (busy) begin
      remain_q <= remain_q - 1'b1;
    end
  end

endmodule : vrt_vector_unit

// File: hdl/vrt_runtime_fsm.sv
// ******************************
// Runtime control, one-cycle registered reaction to its inputs
// The enable masks only the start, counting ends once drained
// ******************************

`timescale 1ns/1ps

module vrt_runtime_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic sw_en_i,
  input  logic accept_i,
  input  logic drained_i,
  output logic cnt_en_o,
  output logic capture_o,
  output logic counting_o,
  output logic pending_o
);

  vrt_pkg::rt_state_e state_q, state_d;
  logic               pending_q, pending_d;

  // Refresh the buffer when everything has drained and nothing new arrives
  assign capture_o = pending_q && drained_i && !accept_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      vrt_pkg::RtOff: begin
        // First instruction seen with software permission starts the count
        if (accept_i && sw_en_i) state_d = vrt_pkg::RtRun;
      end
      vrt_pkg::RtRun: begin
        // Stop only once software has let go and the unit has emptied
        if (!sw_en_i && drained_i) state_d = vrt_pkg::RtDrain;
      end
      vrt_pkg::RtDrain: begin
        if (accept_i && sw_en_i) begin
          state_d = vrt_pkg::RtRun;
        end else if (capture_o || !pending_q) begin
          // The update may already have happened on the way in
          state_d = vrt_pkg::RtOff;
        end
      end
      default: state_d = vrt_pkg::RtOff;
    endcase
  end

  // Any accept owes an update, a capture settles it
  always_comb begin
    pending_d = pending_q;
    if (accept_i) begin
      pending_d = 1'b1;
    end else if (capture_o) begin
      pending_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= vrt_pkg::RtOff;
      pending_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
    end
  end

  assign counting_o = (state_q == vrt_pkg::RtRun);
  // Instructions sent without the enable do not add to the runtime
  assign cnt_en_o   = counting_o;
  assign pending_o  = pending_q;

endmodule : vrt_runtime_fsm

// File: hdl/vrt_runtime_counter.sv
// ******************************
// Cumulative runtime count and its capture buffer
// The count is never cleared after reset, software takes deltas
// ******************************

`timescale 1ns/1ps

module vrt_runtime_counter (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  logic                             capture_i,
  output logic [vrt_pkg::RuntimeWidth-1:0] runtime_o
);

  logic [vrt_pkg::RuntimeWidth-1:0] cnt_q;
  logic [vrt_pkg::RuntimeWidth-1:0] buf_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      buf_q <= '0;
    end else begin
      // 64 bits will not wrap in any realistic run
      if (en_i) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Buffer takes the count as it stands before this edge's increment
      if (capture_i) begin
        buf_q <= cnt_q;
      end
    end
  end

  // Software only ever sees the captured value
  assign runtime_o = buf_q;

endmodule : vrt_runtime_counter

// File: hdl/vrt_apb_regs.sv
// ******************************
// APB register block, zero wait states
// Unmapped offsets and writes to read-only registers raise PSLVERR
// ******************************

`timescale 1ns/1ps

module vrt_apb_regs (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [vrt_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [vrt_pkg::ApbDataWidth-1:0] pwdata_i,
  output logic [vrt_pkg::ApbDataWidth-1:0] prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  input  logic                             counting_i,
  input  logic                             pending_i,
  input  logic                             idle_i,
  input  logic [vrt_pkg::RuntimeWidth-1:0] runtime_i,
  output logic                             sw_en_o
);

  logic access;
  logic hit_ctrl;
  logic hit_ro;
  logic sw_en_q;

  // Access phase of a transfer
  assign access = psel_i && penable_i;

  assign hit_ctrl = (paddr_i == vrt_pkg::RegCtrl);
  // Status and both runtime words can only be read
  assign hit_ro   = (paddr_i == vrt_pkg::RegStatus)    ||
                    (paddr_i == vrt_pkg::RegRuntimeLo) ||
                    (paddr_i == vrt_pkg::RegRuntimeHi);

  assign pready_o  = 1'b1;
  assign pslverr_o = access && (!(hit_ctrl || hit_ro) || (pwrite_i && hit_ro));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sw_en_q <= 1'b0;
    end else if (access && pwrite_i && hit_ctrl) begin
      sw_en_q <= pwdata_i[0];
    end
  end

  assign sw_en_o = sw_en_q;

  // Read data is combinational so it is ready in the access phase
  always_comb begin
    prdata_o = '0;
    if (psel_i && !pwrite_i) begin
      unique case (paddr_i)
        vrt_pkg::RegCtrl: prdata_o[0] = sw_en_q;
        vrt_pkg::RegStatus: begin
          prdata_o[vrt_pkg::StatusCountingBit] = counting_i;
          prdata_o[vrt_pkg::StatusPendingBit]  = pending_i;
          prdata_o[vrt_pkg::StatusIdleBit]     = idle_i;
        end
        vrt_pkg::RegRuntimeLo: prdata_o = runtime_i[vrt_pkg::ApbDataWidth-1:0];
        vrt_pkg::RegRuntimeHi: begin
          prdata_o = runtime_i[vrt_pkg::RuntimeWidth-1:vrt_pkg::ApbDataWidth];
        end
        default: prdata_o = '0;
      endcase
    end
  end

endmodule : vrt_apb_regs

// File: hdl/vrt_top.sv
// ******************************
// Vector runtime measurement subsystem
// Dispatcher must respect credits, there is no other back-pressure
// ******************************

`timescale 1ns/1ps

module vrt_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             instr_valid_i,
  input  logic [vrt_pkg::InstrWidth-1:0]   instr_i,
  output logic                             credit_o,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [vrt_pkg::ApbAddrWidth-1:0] paddr_i,
  input  logic [vrt_pkg::ApbDataWidth-1:0] pwdata_i,
  output logic [vrt_pkg::ApbDataWidth-1:0] prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  output logic                             idle_o,
  output logic [vrt_pkg::RuntimeWidth-1:0] runtime_o
);

  logic                           queue_valid;
  logic [vrt_pkg::InstrWidth-1:0] queue_data;
  logic                           queue_empty;
  logic                           pop;
  logic                           unit_idle;
  logic                           drained;
  logic                           sw_en;
  logic                           cnt_en;
  logic                           capture;
  logic                           counting;
  logic                           pending;

  // Nothing in flight and nothing waiting
  assign drained = unit_idle && queue_empty;
  assign idle_o  = unit_idle;

  vrt_instr_queue i_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (instr_valid_i),
    .data_i  (instr_i),
    .pop_i   (pop),
    .valid_o (queue_valid),
    .data_o  (queue_data),
    .empty_o (queue_empty),
    .credit_o(credit_o)
  );

  vrt_vector_unit i_unit (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .valid_i(queue_valid),
    .instr_i(queue_data),
    .pop_o  (pop),
    .idle_o (unit_idle)
  );

  // A queue push is the accept of an instruction
  vrt_runtime_fsm i_fsm (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .sw_en_i   (sw_en),
    .accept_i  (instr_valid_i),
    .drained_i (drained),
    .cnt_en_o  (cnt_en),
    .capture_o (capture),
    .counting_o(counting),
    .pending_o (pending)
  );

  vrt_runtime_counter i_counter (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (cnt_en),
    .capture_i(capture),
    .runtime_o(runtime_o)
  );

  vrt_apb_regs i_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .counting_i(counting),
    .pending_i (pending),
    .idle_i    (unit_idle),
    .runtime_i (runtime_o),
    .sw_en_o   (sw_en)
  );

endmodule : vrt_top

// File: sim/vrt_assert.sv
// ******************************
// Checker bound into vrt_top, keeps its own models of credits,
// queue occupancy and busy time from the protocol rules
// ******************************

`timescale 1ns/1ps

module vrt_assert (
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             push_i,
  input logic                             credit_i,
  input logic                             pop_i,
  input logic [vrt_pkg::InstrWidth-1:0]   instr_i,
  input logic                             idle_i,
  input logic                             queue_empty_i,
  input logic                             pending_i,
  input logic                             drained_i,
  input logic [vrt_pkg::RuntimeWidth-1:0] runtime_i
);

  // Credits the dispatcher should hold, and entries the queue should hold
  logic [vrt_pkg::CreditWidth-1:0]   credits_q;
  logic [vrt_pkg::CreditWidth-1:0]   occupancy_q;
  // Length of the instruction in flight and the busy cycles seen so far
  logic [vrt_pkg::InstrLenWidth-1:0] exp_len_q;
  logic [vrt_pkg::InstrLenWidth:0]   low_cnt_q;
  logic [vrt_pkg::InstrLenWidth-1:0] pop_len;

  // A zero length field still means one cycle of work
  assign pop_len = (instr_i[vrt_pkg::InstrLenWidth-1:0] == '0) ?
                   1'b1 : instr_i[vrt_pkg::InstrLenWidth-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credits_q   <= vrt_pkg::CreditWidth'(vrt_pkg::QueueDepth);
      occupancy_q <= '0;
      exp_len_q   <= '0;
      low_cnt_q   <= '0;
    end else begin
      credits_q   <= credits_q + credit_i - push_i;
      occupancy_q <= occupancy_q + push_i - pop_i;
      if (pop_i) begin
        exp_len_q <= pop_len;
        low_cnt_q <= '0;
      end else if (!idle_i) begin
        low_cnt_q <= low_cnt_q + 1'b1;
      end
    end
  end

  a_push_has_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> credits_q != '0)
    else begin $error("push without a credit"); vrt_tb.errors++; end

  a_push_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> occupancy_q < vrt_pkg::QueueDepth)
    else begin $error("push into a full queue"); vrt_tb.errors++; end

  // All credits are home once the queue is empty and no pulse is in flight
  a_credits_home: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (queue_empty_i && !credit_i) |-> credits_q == vrt_pkg::QueueDepth)
    else begin $error("credits lost or duplicated"); vrt_tb.errors++; end

  a_credit_after_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_i |-> $past(pop_i))
    else begin $error("credit pulse without a pop"); vrt_tb.errors++; end

  // Unit goes busy right after a pop and stays busy for exactly the length
  a_busy_after_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |=> !idle_i)
    else begin $error("unit idle after a pop"); vrt_tb.errors++; end

  a_exec_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(idle_i) |-> low_cnt_q == exp_len_q)
    else begin $error("busy time differs from length"); vrt_tb.errors++; end

  a_runtime_update: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$stable(runtime_i) |-> $past(pending_i && drained_i))
    else begin $error("runtime changed outside an update"); vrt_tb.errors++; end

endmodule : vrt_assert

// File: sim/vrt_tb.sv
// ******************************
// Testbench acting as a credited dispatcher and APB master
// Inputs change on the falling edge, outputs are sampled on the rising one
// ******************************

`timescale 1ns/1ps

module vrt_tb;

  localparam logic [31:0] Seed   = 32'h8cd738a2;
  localparam int ClkPeriod       = 20;
  localparam int ResetCycles     = 16;
  // Instructions sent over all tests, used to size the watchdog
  localparam int TotalInstr      = 38;
  localparam int WatchdogCycles  = TotalInstr * 40 + 2000;

  logic                             clk;
  logic                             rst_n;
  logic                             instr_valid;
  logic [vrt_pkg::InstrWidth-1:0]   instr;
  logic                             credit;
  logic                             psel, penable, pwrite, pready, pslverr, idle;
  logic [vrt_pkg::ApbAddrWidth-1:0] paddr;
  logic [vrt_pkg::ApbDataWidth-1:0] pwdata, prdata;
  logic [vrt_pkg::RuntimeWidth-1:0] runtime;
  logic [31:0]                      rng_state;
  int errors, tests, credits, pushed, credit_pulses;

  vrt_top UUT (
    .clk_i(clk), .rst_ni(rst_n), .instr_valid_i(instr_valid), .instr_i(instr),
    .credit_o(credit), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .idle_o(idle), .runtime_o(runtime)
  );

  bind vrt_top vrt_assert u_assert (
    .clk_i(clk_i), .rst_ni(rst_ni), .push_i(instr_valid_i), .credit_i(credit_o),
    .pop_i(pop), .instr_i(queue_data), .idle_i(idle_o), .queue_empty_i(queue_empty),
    .pending_i(pending), .drained_i(drained), .runtime_i(runtime_o)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

  // Dispatcher credit count, spent on each push and refilled by each pulse
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits       <= vrt_pkg::QueueDepth;
      pushed        <= 0;
      credit_pulses <= 0;
    end else begin
      credits       <= credits + credit - instr_valid;
      pushed        <= pushed + instr_valid;
      credit_pulses <= credit_pulses + credit;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic expect_true(input bit cond, input string msg);
    assert (cond) else begin
      $display("error %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s finished at %0t, errors so far %0d", name, $time, errors);
  endtask

  // Sends n random instructions as fast as credits allow, sums their lengths
  task automatic send_burst(input int n, output int len_sum);
    int sent;
    logic [vrt_pkg::InstrLenWidth-1:0] len;
    sent    = 0;
    len_sum = 0;
    while (sent < n) begin
      @(negedge clk);
      if (credits > 0) begin
        rng_state   = xorshift(rng_state);
        len         = rng_state[vrt_pkg::InstrLenWidth-1:0];
        instr       = {sent[vrt_pkg::InstrIdWidth-1:0], len};
        instr_valid = 1'b1;
        len_sum    += (len == '0) ? 1 : int'(len);
        sent++;
      end else begin
        instr_valid = 1'b0;
      end
    end
    @(negedge clk);
    instr_valid = 1'b0;
  endtask

  task automatic apb_xfer(input logic write, input logic [11:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    // Access phase completes on this edge
    @(posedge clk);
    rdata = prdata;
    err   = pslverr;
    // Zero wait states, so the slave is always ready in the access phase
    expect_true(pready, "PREADY low in the access phase");
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Polls status until the unit is idle and the buffer update has landed
  task automatic wait_settled();
    logic [31:0] status;
    logic        err;
    do begin
      apb_xfer(1'b0, vrt_pkg::RegStatus, '0, status, err);
    end while (!status[vrt_pkg::StatusIdleBit] || status[vrt_pkg::StatusPendingBit]);
  endtask

  task automatic read_runtime(output logic [63:0] value);
    logic [31:0] lo, hi;
    logic        err;
    apb_xfer(1'b0, vrt_pkg::RegRuntimeLo, '0, lo, err);
    apb_xfer(1'b0, vrt_pkg::RegRuntimeHi, '0, hi, err);
    value = {hi, lo};
    // The observation port shows the same buffered value as the registers
    expect_true(value == runtime, "runtime_o differs from the APB runtime words");
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [63:0] rt_start, rt_a, rt_b;
    int          sum_a, sum_b;
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    errors = 0;
    tests = 0;
    rng_state = Seed;
    repeat (ResetCycles) @(negedge clk);
    rst_n = 1'b1;

    // Enable is still clear from reset so nothing may be counted
    send_burst(6, sum_a);
    wait_settled();
    apb_xfer(1'b0, vrt_pkg::RegStatus, '0, rdata, err);
    expect_true(!rdata[vrt_pkg::StatusCountingBit], "counting while enable is clear");
    read_runtime(rt_start);
    expect_true(rt_start == 0, "runtime moved while enable is clear");
    finish_test("enable_gating");

    apb_xfer(1'b1, vrt_pkg::RegCtrl, 32'h1, rdata, err);
    send_burst(10, sum_a);
    apb_xfer(1'b1, vrt_pkg::RegCtrl, 32'h0, rdata, err);
    wait_settled();
    read_runtime(rt_a);
    expect_true(rt_a >= sum_a, "runtime below the summed lengths");
    expect_true(rt_a - rt_start <= sum_a + 10 + 2, "runtime above lengths plus issue cycles");
    finish_test("runtime_bounds");

    // Enable stays set across both bursts so the second read must grow
    apb_xfer(1'b1, vrt_pkg::RegCtrl, 32'h1, rdata, err);
    send_burst(8, sum_a);
    wait_settled();
    read_runtime(rt_a);
    send_burst(8, sum_b);
    wait_settled();
    read_runtime(rt_b);
    expect_true(rt_b > rt_a, "second update not larger than the first");
    apb_xfer(1'b1, vrt_pkg::RegCtrl, 32'h0, rdata, err);
    finish_test("re_update");

    apb_xfer(1'b1, vrt_pkg::RegRuntimeLo, 32'h1234, rdata, err);
    expect_true(err, "no PSLVERR on a write to RegRuntimeLo");
    apb_xfer(1'b0, 12'h010, '0, rdata, err);
    expect_true(err, "no PSLVERR on a read of an unmapped offset");
    apb_xfer(1'b1, vrt_pkg::RegCtrl, 32'h1, rdata, err);
    apb_xfer(1'b0, vrt_pkg::RegCtrl, '0, rdata, err);
    expect_true(rdata[0] && !err, "CTRL does not read back 1");
    apb_xfer(1'b1, vrt_pkg::RegCtrl, 32'h0, rdata, err);
    apb_xfer(1'b0, vrt_pkg::RegCtrl, '0, rdata, err);
    expect_true(!rdata[0] && !err, "CTRL does not read back 0");
    finish_test("apb_errors");

    send_burst(6, sum_a);
    wait_settled();
    expect_true(idle, "unit not idle after the last burst");
    expect_true(pushed == credit_pulses, "credit pulses differ from accepted instructions");
    expect_true(credits == vrt_pkg::QueueDepth, "dispatcher did not get all credits back");
    finish_test("credits");

    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : vrt_tb

// File: vrt_runtime.f
hdl/vrt_pkg.sv
hdl/vrt_instr_queue.sv
hdl/vrt_vector_unit.sv
hdl/vrt_runtime_fsm.sv
hdl/vrt_runtime_counter.sv
hdl/vrt_apb_regs.sv
hdl/vrt_top.sv
sim/vrt_assert.sv
sim/vrt_tb.sv
